// ==== include/periph_consts.svh ====
/*
 * Peripheral subsystem constants
 * Bus widths, request credits, interrupt sources and the register map
 */
`ifndef PERIPH_CONSTS_SVH
`define PERIPH_CONSTS_SVH

`define PERIPH_DATA_W       32
`define PERIPH_ADDR_W       8
`define PERIPH_REQ_CREDITS  2
`define PERIPH_NUM_SRC      8

// Window numbers, address bits 7:4
`define PERIPH_TIMER_BASE   4'd0
`define PERIPH_IRQ_BASE     4'd1
`define PERIPH_ERR_DATA     32'hDEADBEEF

// Timer register offsets
`define TIMER_CTRL          4'd0
`define TIMER_CMP0          4'd1
`define TIMER_CMP1          4'd2
`define TIMER_CNT0          4'd3
`define TIMER_CNT1          4'd4

// Interrupt controller register offsets
`define IRQ_ENABLE          4'd0
`define IRQ_PENDING         4'd1
`define IRQ_CLAIM           4'd2

`endif

// ==== src/periph_pkg.sv ====
/*
 * Peripheral subsystem types
 * Register bus request/response structs, steered access and FSM enums
 */
`include "periph_consts.svh"

package periph_pkg;

    // ------------------------------------------------------------------------
    // Register bus payloads
    // ------------------------------------------------------------------------

    // Host request, word addressed
    typedef struct packed {
        logic                      write;
        logic [`PERIPH_ADDR_W-1:0] addr;
        logic [`PERIPH_DATA_W-1:0] wdata;
    } reg_req_t;

    // One response per request, in order
    typedef struct packed {
        logic [`PERIPH_DATA_W-1:0] rdata;
        logic                      error;
    } reg_rsp_t;

    // Access as seen by a peripheral, window bits already stripped
    typedef struct packed {
        logic                      write;
        logic [3:0]                offset;
        logic [`PERIPH_DATA_W-1:0] wdata;
    } reg_acc_t;

    // ------------------------------------------------------------------------
    // Control encodings
    // ------------------------------------------------------------------------
    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        RESP
    } bus_state_e;

    typedef enum logic [1:0] {
        TGT_TIMER,
        TGT_IRQ,
        TGT_ERR
    } bus_target_e;

endpackage

// ==== src/reg_req_fifo.sv ====
/*
 * Register request queue
 * Small circular buffer whose depth equals the host's credit count
 */
`timescale 1ns/1ns
`include "periph_consts.svh"

module reg_req_fifo (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 push_i,
    input  periph_pkg::reg_req_t req_i,
    input  logic                 pop_i,
    output periph_pkg::reg_req_t head_o,
    output logic                 not_empty_o
);
    import periph_pkg::*;

    localparam int Depth = `PERIPH_REQ_CREDITS;
    localparam int PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CntW  = $clog2(Depth + 1);

    reg_req_t        mem_q [Depth];
    logic [PtrW-1:0] wr_ptr_q;
    logic [PtrW-1:0] rd_ptr_q;
    logic [CntW-1:0] fill_q;

    function automatic logic [PtrW-1:0] ptr_next(input logic [PtrW-1:0] ptr);
        return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= req_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            fill_q   <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (pop_i) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            case ({push_i, pop_i})
                2'b10:   fill_q <= fill_q + 1'b1;
                2'b01:   fill_q <= fill_q - 1'b1;
                default: fill_q <= fill_q;
            endcase
        end
    end

    assign head_o      = mem_q[rd_ptr_q];
    assign not_empty_o = (fill_q != '0);

    // Host must hold a credit for every request it sends
    a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        push_i |-> (fill_q != CntW'(Depth)));

    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pop_i |-> not_empty_o);

endmodule

// ==== src/reg_bus_fsm.sv ====
/*
 * Register bus front end
 * Pops queued requests, decodes the window, strobes one peripheral
 * and returns the response, answering unmapped windows itself
 */
`timescale 1ns/1ns
`include "periph_consts.svh"

module reg_bus_fsm (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  periph_pkg::reg_req_t      head_i,
    input  logic                      not_empty_i,
    output logic                      pop_o,
    output periph_pkg::reg_acc_t      acc_o,
    output logic                      timer_sel_o,
    output logic                      irq_sel_o,
    input  logic [`PERIPH_DATA_W-1:0] timer_rdata_i,
    input  logic [`PERIPH_DATA_W-1:0] irq_rdata_i,
    output logic                      rsp_valid_o,
    output periph_pkg::reg_rsp_t      rsp_o
);
    import periph_pkg::*;

    bus_state_e  state_q;
    bus_state_e  state_d;
    bus_target_e tgt;
    reg_req_t    req_q;
    reg_rsp_t    rsp_q;

    // ------------------------------------------------------------------------
    // State sequencing
    // ------------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (not_empty_i) begin
                    state_d = ACCESS;
                end
            end
            ACCESS:  state_d = RESP;
            RESP:    state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign pop_o = (state_q == IDLE) && not_empty_i;

    // Request held for the whole access
    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            req_q <= head_i;
        end
    end

    // ------------------------------------------------------------------------
    // Address decode and steering
    // ------------------------------------------------------------------------
    always_comb begin
        case (req_q.addr[7:4])
            `PERIPH_TIMER_BASE: tgt = TGT_TIMER;
            `PERIPH_IRQ_BASE:   tgt = TGT_IRQ;
            default:            tgt = TGT_ERR;
        endcase
    end

    assign acc_o.write  = req_q.write;
    assign acc_o.offset = req_q.addr[3:0];
    assign acc_o.wdata  = req_q.wdata;

    assign timer_sel_o = (state_q == ACCESS) && (tgt == TGT_TIMER);
    assign irq_sel_o   = (state_q == ACCESS) && (tgt == TGT_IRQ);

    // Read data sampled at the same edge the peripheral acts on
    always_ff @(posedge clk_i) begin
        if (state_q == ACCESS) begin
            case (tgt)
                TGT_TIMER: rsp_q <= '{rdata: timer_rdata_i, error: 1'b0};
                TGT_IRQ:   rsp_q <= '{rdata: irq_rdata_i, error: 1'b0};
                default:   rsp_q <= '{rdata: `PERIPH_ERR_DATA, error: 1'b1};
            endcase
        end
    end

    assign rsp_valid_o = (state_q == RESP);
    assign rsp_o       = rsp_q;

    a_one_target: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0({timer_sel_o, irq_sel_o}));

endmodule

// ==== src/periph_timer.sv ====
/*
 * Two-channel timer
 * Free counters that wrap on their compare value and pulse an interrupt
 */
`timescale 1ns/1ns
`include "periph_consts.svh"

module periph_timer (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      sel_i,
    input  periph_pkg::reg_acc_t      acc_i,
    output logic [`PERIPH_DATA_W-1:0] rdata_o,
    output logic [1:0]                tick_o
);
    import periph_pkg::*;

    localparam int NumCh = 2;

    logic [NumCh-1:0]                     ctrl_q;
    logic [NumCh-1:0][`PERIPH_DATA_W-1:0] cmp_q;
    logic [NumCh-1:0][`PERIPH_DATA_W-1:0] cnt_q;
    logic [NumCh-1:0]                     tick_q;

    // Register writes, read-only offsets fall through
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctrl_q <= '0;
            cmp_q  <= '0;
        end else if (sel_i && acc_i.write) begin
            case (acc_i.offset)
                `TIMER_CTRL: ctrl_q   <= acc_i.wdata[NumCh-1:0];
                `TIMER_CMP0: cmp_q[0] <= acc_i.wdata;
                `TIMER_CMP1: cmp_q[1] <= acc_i.wdata;
                default:     ctrl_q   <= ctrl_q;
            endcase
        end
    end

    // Counters, wrap to 0 on match
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q  <= '0;
            tick_q <= '0;
        end else begin
            for (int ch = 0; ch < NumCh; ch++) begin
                tick_q[ch] <= 1'b0;
                if (ctrl_q[ch]) begin
                    if (cnt_q[ch] == cmp_q[ch]) begin
                        cnt_q[ch]  <= '0;
                        tick_q[ch] <= 1'b1;
                    end else begin
                        cnt_q[ch] <= cnt_q[ch] + 1'b1;
                    end
                end
            end
        end
    end

    assign tick_o = tick_q;

    always_comb begin
        rdata_o = '0;
        case (acc_i.offset)
            `TIMER_CTRL: rdata_o[NumCh-1:0] = ctrl_q;
            `TIMER_CMP0: rdata_o = cmp_q[0];
            `TIMER_CMP1: rdata_o = cmp_q[1];
            `TIMER_CNT0: rdata_o = cnt_q[0];
            `TIMER_CNT1: rdata_o = cnt_q[1];
            default:     rdata_o = '0;
        endcase
    end

endmodule

// ==== src/irq_gateway.sv ====
/*
 * Interrupt controller, single target
 * Level sources with enable mask, pending bits and claim/complete
 */
`timescale 1ns/1ns
`include "periph_consts.svh"

module irq_gateway (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      sel_i,
    input  periph_pkg::reg_acc_t      acc_i,
    input  logic [`PERIPH_NUM_SRC-1:0] src_i,
    output logic [`PERIPH_DATA_W-1:0] rdata_o,
    output logic                      irq_o
);
    import periph_pkg::*;

    localparam int N     = `PERIPH_NUM_SRC;
    localparam int DataW = `PERIPH_DATA_W;
    localparam int IdW   = $clog2(N + 1);

    logic [N-1:0]   enable_q;
    logic [N-1:0]   pending_q;
    logic [N-1:0]   in_service_q;
    logic [N-1:0]   pend_en;
    logic [N-1:0]   claim_oh;
    logic [N-1:0]   cmpl_oh;
    logic [IdW-1:0] claim_id;
    logic           claim_rd;
    logic           cmpl_wr;

    assign pend_en  = pending_q & enable_q;
    assign claim_rd = sel_i && !acc_i.write && (acc_i.offset == `IRQ_CLAIM);
    assign cmpl_wr  = sel_i && acc_i.write && (acc_i.offset == `IRQ_CLAIM);

    // ------------------------------------------------------------------------
    // Claim and complete decode
    // ------------------------------------------------------------------------

    // Lowest numbered source wins, ID is source plus one
    always_comb begin
        claim_id = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (pend_en[i]) begin
                claim_id = IdW'(i + 1);
            end
        end
    end

    assign claim_oh = claim_rd ? (pend_en & (~pend_en + 1'b1)) : '0;

    always_comb begin
        for (int i = 0; i < N; i++) begin
            cmpl_oh[i] = cmpl_wr && (acc_i.wdata == DataW'(i + 1));
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            enable_q     <= '0;
            pending_q    <= '0;
            in_service_q <= '0;
        end else begin
            if (sel_i && acc_i.write && (acc_i.offset == `IRQ_ENABLE)) begin
                enable_q <= acc_i.wdata[N-1:0];
            end
            // A source in service is gated until completed
            pending_q    <= (pending_q | (src_i & ~in_service_q)) & ~claim_oh;
            in_service_q <= (in_service_q | claim_oh) & ~cmpl_oh;
        end
    end

    assign irq_o = |pend_en;

    always_comb begin
        rdata_o = '0;
        case (acc_i.offset)
            `IRQ_ENABLE:  rdata_o[N-1:0]   = enable_q;
            `IRQ_PENDING: rdata_o[N-1:0]   = pending_q;
            `IRQ_CLAIM:   rdata_o[IdW-1:0] = claim_id;
            default:      rdata_o = '0;
        endcase
    end

    a_pend_xor_service: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (pending_q & in_service_q) == '0);

endmodule

// ==== src/periph_subsys.sv ====
/*
 * Peripheral subsystem top
 * Credit-based register bus front end with a timer and interrupt controller
 */
`timescale 1ns/1ns

module periph_subsys (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 req_valid_i,
    input  periph_pkg::reg_req_t req_i,
    output logic                 credit_o,
    output logic                 rsp_valid_o,
    output periph_pkg::reg_rsp_t rsp_o,
    input  logic [5:0]           irq_ext_i,
    output logic                 irq_o
);
    import periph_pkg::*;

    // Response struct is read data plus the error flag
    localparam int DataW = $bits(reg_rsp_t) - 1;

    reg_req_t         head;
    reg_acc_t         acc;
    logic             not_empty;
    logic             pop;
    logic             timer_sel;
    logic             irq_sel;
    logic [DataW-1:0] timer_rdata;
    logic [DataW-1:0] irq_rdata;
    logic [1:0]       tick;
    logic [7:0]       irq_src;

    // Each pop frees one queue slot back to the host
    assign credit_o = pop;

    // Timer channels take sources 0 and 1
    assign irq_src = {irq_ext_i, tick};

    // ------------------------------------------------------------------------
    // Request path
    // ------------------------------------------------------------------------
    reg_req_fifo i_req_fifo (
        .clk_i       ( clk_i       ),
        .rst_n_i     ( rst_n_i     ),
        .push_i      ( req_valid_i ),
        .req_i       ( req_i       ),
        .pop_i       ( pop         ),
        .head_o      ( head        ),
        .not_empty_o ( not_empty   )
    );

    reg_bus_fsm i_bus_fsm (
        .clk_i         ( clk_i       ),
        .rst_n_i       ( rst_n_i     ),
        .head_i        ( head        ),
        .not_empty_i   ( not_empty   ),
        .pop_o         ( pop         ),
        .acc_o         ( acc         ),
        .timer_sel_o   ( timer_sel   ),
        .irq_sel_o     ( irq_sel     ),
        .timer_rdata_i ( timer_rdata ),
        .irq_rdata_i   ( irq_rdata   ),
        .rsp_valid_o   ( rsp_valid_o ),
        .rsp_o         ( rsp_o       )
    );

    // ------------------------------------------------------------------------
    // Peripherals
    // ------------------------------------------------------------------------
    periph_timer i_timer (
        .clk_i   ( clk_i       ),
        .rst_n_i ( rst_n_i     ),
        .sel_i   ( timer_sel   ),
        .acc_i   ( acc         ),
        .rdata_o ( timer_rdata ),
        .tick_o  ( tick        )
    );

    irq_gateway i_irq_gateway (
        .clk_i   ( clk_i     ),
        .rst_n_i ( rst_n_i   ),
        .sel_i   ( irq_sel   ),
        .acc_i   ( acc       ),
        .src_i   ( irq_src   ),
        .rdata_o ( irq_rdata ),
        .irq_o   ( irq_o     )
    );

endmodule

// ==== verif/tb_periph_subsys.sv ====
/*
 * Peripheral subsystem testbench
 * Replays register bus vectors with credit flow control and checks
 * responses in order along with the target interrupt
 */
`timescale 1ns/1ns
`include "periph_consts.svh"

module tb_periph_subsys;
    import periph_pkg::*;

    localparam int CyclesPerLine = 200;
    localparam int PollLimit     = 50;

    typedef struct packed {
        logic [8*8-1:0]  op;
        logic [7:0]      addr;
        logic [31:0]     data;
        logic [31:0]     exp;
        logic            err;
        logic [8*16-1:0] tag;
    } vector_t;

    typedef struct packed {
        logic [31:0]     data;
        logic [31:0]     mask;
        logic            err;
        logic [8*16-1:0] tag;
    } exp_rsp_t;

    logic       clk;
    logic       rst_n;
    logic       req_valid;
    reg_req_t   req;
    logic       credit;
    logic       rsp_valid;
    reg_rsp_t   rsp;
    logic [5:0] irq_ext;
    logic       irq;

    vector_t     vectors[$];
    exp_rsp_t    exp_q[$];
    int          credits      = `PERIPH_REQ_CREDITS;
    int          credit_seen  = 0;
    int          mismatches   = 0;
    int          other_errors = 0;
    int          cycles       = 0;
    int          cycle_limit  = 0;
    logic        gaps_on      = 1'b1;
    logic [7:0]  lfsr_q       = 8'd7;
    logic [31:0] last_rdata   = '0;

    periph_subsys UUT (
        .clk_i       ( clk       ),
        .rst_n_i     ( rst_n     ),
        .req_valid_i ( req_valid ),
        .req_i       ( req       ),
        .credit_o    ( credit    ),
        .rsp_valid_o ( rsp_valid ),
        .rsp_o       ( rsp       ),
        .irq_ext_i   ( irq_ext   ),
        .irq_o       ( irq       )
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Taps 8,6,5,4
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    function automatic exp_rsp_t make_exp(input logic [31:0] data, input logic [31:0] mask,
                                          input logic err, input logic [8*16-1:0] tag);
        exp_rsp_t e;
        e.data = data;
        e.mask = mask;
        e.err  = err;
        e.tag  = tag;
        return e;
    endfunction

    // ------------------------------------------------------------------------
    // One cycle of the host, credit return and response check
    // ------------------------------------------------------------------------
    task automatic tick_cycle;
        exp_rsp_t e;
        @(negedge clk);
        req_valid   = 1'b0;
        // Credit seen last cycle becomes usable now
        credits     = credits + credit_seen;
        credit_seen = credit;
        if (credits > `PERIPH_REQ_CREDITS) begin
            $display("host credit count rose to %0d, above the queue depth", credits);
            other_errors++;
        end
        if (rsp_valid) begin
            last_rdata = rsp.rdata;
            if (exp_q.size() == 0) begin
                $display("a response arrived with no request outstanding");
                other_errors++;
            end else begin
                e = exp_q.pop_front();
                if (rsp.error !== e.err) begin
                    $display("mismatch %0s error flag: expected %0d, actual %0d",
                             e.tag, e.err, rsp.error);
                    mismatches++;
                end
                if ((rsp.rdata & e.mask) !== (e.data & e.mask)) begin
                    $display("mismatch %0s read data: expected %h, actual %h",
                             e.tag, e.data & e.mask, rsp.rdata & e.mask);
                    mismatches++;
                end
            end
        end
    endtask

    task automatic drain;
        while (exp_q.size() != 0) begin
            tick_cycle();
        end
    endtask

    task automatic issue(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
                         input exp_rsp_t e);
        int gap;
        gap = 0;
        if (gaps_on) begin
            lfsr_q = lfsr_next(lfsr_q);
            gap    = lfsr_q[0];
            lfsr_q = lfsr_next(lfsr_q);
            gap    = gap * 2 + lfsr_q[0];
        end
        repeat (gap) tick_cycle();
        tick_cycle();
        // Stall while the host holds no credit
        while (credits == 0) begin
            tick_cycle();
        end
        req.write = write;
        req.addr  = addr;
        req.wdata = wdata;
        req_valid = 1'b1;
        credits   = credits - 1;
        exp_q.push_back(e);
    endtask

    task automatic load_vectors;
        int               fd;
        int               n;
        logic [8*128-1:0] line;
        logic [8*8-1:0]   op;
        logic [7:0]       addr;
        logic [31:0]      data;
        logic [31:0]      exp;
        logic             err;
        logic [8*16-1:0]  tag;
        vector_t          v;
        fd = $fopen("verif/periph_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file verif/periph_vectors.txt");
            other_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                if ($fgets(line, fd) != 0) begin
                    n = $sscanf(line, "%s %h %h %h %h %s", op, addr, data, exp, err, tag);
                    if (n == 6) begin
                        v = '{op: op, addr: addr, data: data, exp: exp, err: err, tag: tag};
                        vectors.push_back(v);
                    end
                end
            end
            $fclose(fd);
            if (vectors.size() == 0) begin
                $display("the vector file holds no operations");
                other_errors++;
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Operation dispatch
    // ------------------------------------------------------------------------
    task automatic run_vector(input vector_t v);
        logic [31:0] first_val;
        int          tries;
        if (v.op == "WR") begin
            issue(1'b1, v.addr, v.data, make_exp(v.exp, v.err ? '1 : '0, v.err, v.tag));
        end else if (v.op == "RD") begin
            issue(1'b0, v.addr, '0, make_exp(v.exp, v.data, v.err, v.tag));
        end else if (v.op == "EXT") begin
            drain();
            tick_cycle();
            irq_ext = v.data[5:0];
        end else if (v.op == "IRQ") begin
            drain();
            tick_cycle();
            if (irq !== v.exp[0]) begin
                $display("mismatch %0s irq: expected %0d, actual %0d", v.tag, v.exp[0], irq);
                mismatches++;
            end
        end else if (v.op == "POLL") begin
            tries = 0;
            do begin
                issue(1'b0, v.addr, '0, make_exp('0, '0, 1'b0, v.tag));
                drain();
                tries++;
            end while (((last_rdata & v.data) != v.exp) && (tries < PollLimit));
            if ((last_rdata & v.data) != v.exp) begin
                $display("mismatch %0s poll: expected %h, actual %h",
                         v.tag, v.exp, last_rdata & v.data);
                mismatches++;
            end
        end else if (v.op == "STABLE") begin
            issue(1'b0, v.addr, '0, make_exp('0, '0, 1'b0, v.tag));
            drain();
            first_val = last_rdata;
            issue(1'b0, v.addr, '0, make_exp('0, '0, 1'b0, v.tag));
            drain();
            if (last_rdata != first_val) begin
                $display("mismatch %0s repeat read: expected %h, actual %h",
                         v.tag, first_val, last_rdata);
                mismatches++;
            end
        end else if (v.op == "GAP") begin
            gaps_on = v.data[0];
        end else begin
            $display("unknown operation in vector file, tag %0s", v.tag);
            other_errors++;
        end
    endtask

    initial begin : watchdog
        wait (cycle_limit != 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
        $display("Simulation failed");
        $finish;
    end

    initial begin : main
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        irq_ext   = '0;
        load_vectors();
        cycle_limit = CyclesPerLine * (vectors.size() + 1);
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        foreach (vectors[i]) begin
            run_vector(vectors[i]);
        end
        drain();
        // Catch any stray response
        repeat (4) tick_cycle();
        if (credits + credit_seen != `PERIPH_REQ_CREDITS) begin
            $display("host ended with %0d credits instead of all returned",
                     credits + credit_seen);
            other_errors++;
        end
        $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
        if (mismatches + other_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+include
src/periph_pkg.sv
src/reg_req_fifo.sv
src/reg_bus_fsm.sv
src/periph_timer.sv
src/irq_gateway.sv
src/periph_subsys.sv
verif/tb_periph_subsys.sv

// ==== verif/periph_vectors.txt ====
# op addr data expected err tag, all numbers hex except err
# data is write data for WR, compare mask for RD and POLL, line levels for EXT
WR 01 0000abcd 00000000 0 round_trip
WR 02 12345678 00000000 0 round_trip
WR 10 000000c3 00000000 0 round_trip
RD 01 ffffffff 0000abcd 0 round_trip
RD 02 ffffffff 12345678 0 round_trip
RD 10 ffffffff 000000c3 0 round_trip
WR 25 11111111 deadbeef 1 unmapped
RD 3f ffffffff deadbeef 1 unmapped
WR f1 22222222 deadbeef 1 unmapped
RD 80 ffffffff deadbeef 1 unmapped
RD 01 ffffffff 0000abcd 0 unmapped
RD 02 ffffffff 12345678 0 unmapped
RD 10 ffffffff 000000c3 0 unmapped
GAP 00 00000000 00000000 0 credit_flow
RD 01 ffffffff 0000abcd 0 credit_flow
RD 02 ffffffff 12345678 0 credit_flow
RD 10 ffffffff 000000c3 0 credit_flow
RD 40 ffffffff deadbeef 1 credit_flow
RD 13 ffffffff 00000000 0 credit_flow
GAP 00 00000001 00000000 0 credit_flow
WR 10 00000020 00000000 0 ext_irq
EXT 00 00000008 00000000 0 ext_irq
IRQ 00 00000000 00000001 0 ext_irq
RD 12 ffffffff 00000006 0 ext_irq
IRQ 00 00000000 00000000 0 ext_irq
EXT 00 00000000 00000000 0 ext_irq
WR 12 00000006 00000000 0 ext_irq
EXT 00 00000008 00000000 0 ext_irq
IRQ 00 00000000 00000001 0 ext_irq
RD 11 ffffffff 00000020 0 ext_irq
RD 12 ffffffff 00000006 0 ext_irq
EXT 00 00000000 00000000 0 ext_irq
WR 12 00000006 00000000 0 ext_irq
EXT 00 00000001 00000000 0 masking
IRQ 00 00000000 00000000 0 masking
RD 11 ffffffff 00000004 0 masking
EXT 00 00000000 00000000 0 masking
WR 10 00000001 00000000 0 timer_irq
WR 01 00000014 00000000 0 timer_irq
WR 00 00000001 00000000 0 timer_irq
POLL 11 00000001 00000001 0 timer_irq
RD 12 ffffffff 00000001 0 timer_irq
IRQ 00 00000000 00000000 0 timer_irq
WR 00 00000000 00000000 0 timer_irq
STABLE 03 00000000 00000000 0 timer_irq
